// ==== rtl/branchPkg.sv ====
`default_nettype none

package branchPkg;

    // operand, immediate, pc and result width
    localparam int dataWidth = 32;

    // tag zero means the operand value is already present
    localparam int unsigned tagFree = 0;

    // branch and jump opcodes where opNop marks a free station entry
    typedef enum logic [3:0] {
        opNop,
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opJal,
        opJalr
    } branchOpE;

endpackage

`default_nettype wire

// ==== rtl/branchRs.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchRs import branchPkg::*; #(
    parameter int rsDepth  = 4,
    parameter int tagWidth = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    // dispatch
    input  logic                 dispValid,
    input  branchOpE             dispOp,
    input  logic [dataWidth-1:0] dispSrc1Data,
    input  logic [tagWidth-1:0]  dispSrc1Tag,
    input  logic [dataWidth-1:0] dispSrc2Data,
    input  logic [tagWidth-1:0]  dispSrc2Tag,
    input  logic [dataWidth-1:0] dispImm,
    input  logic [dataWidth-1:0] dispPc,
    input  logic                 dispPredTaken,
    input  logic [tagWidth-1:0]  dispDestTag,
    output logic                 dispReady,
    // common data bus
    input  logic                 cdbValid,
    input  logic [tagWidth-1:0]  cdbTag,
    input  logic [dataWidth-1:0] cdbData,
    // issue to execute stage
    output logic                 issueValid,
    input  logic                 issueReady,
    output branchOpE             issueOp,
    output logic [dataWidth-1:0] issueSrc1,
    output logic [dataWidth-1:0] issueSrc2,
    output logic [dataWidth-1:0] issueImm,
    output logic [dataWidth-1:0] issuePc,
    output logic                 issuePredTaken,
    output logic [tagWidth-1:0]  issueDestTag
);

    localparam int idxWidth = (rsDepth > 1) ? $clog2(rsDepth) : 1;

    // entry storage
    branchOpE             entryOp       [rsDepth];
    logic [dataWidth-1:0] entrySrc1Data [rsDepth];
    logic [tagWidth-1:0]  entrySrc1Tag  [rsDepth];
    logic [dataWidth-1:0] entrySrc2Data [rsDepth];
    logic [tagWidth-1:0]  entrySrc2Tag  [rsDepth];
    logic [dataWidth-1:0] entryImm      [rsDepth];
    logic [dataWidth-1:0] entryPc       [rsDepth];
    logic                 entryPred     [rsDepth];
    logic [tagWidth-1:0]  entryDestTag  [rsDepth];

    logic [rsDepth-1:0]  freeMask;
    logic [rsDepth-1:0]  readyMask;
    logic [idxWidth-1:0] freeIdx;
    logic [idxWidth-1:0] readyIdx;
    logic                dispFire;
    logic                issueFire;
    logic                src1Hit;
    logic                src2Hit;

    // lowest free entry and lowest ready entry
    always_comb begin
        freeIdx  = '0;
        readyIdx = '0;
        for (int i = rsDepth - 1; i >= 0; i--) begin
            freeMask[i]  = (entryOp[i] == opNop);
            readyMask[i] = !freeMask[i]
                && (entrySrc1Tag[i] == tagWidth'(tagFree))
                && (entrySrc2Tag[i] == tagWidth'(tagFree));
            if (freeMask[i]) begin
                freeIdx = idxWidth'(i);
            end
            if (readyMask[i]) begin
                readyIdx = idxWidth'(i);
            end
        end
    end

    assign dispReady  = |freeMask;
    assign issueValid = |readyMask;
    assign dispFire   = dispValid && dispReady;
    assign issueFire  = issueValid && issueReady;

    // broadcast on the same edge as dispatch
    assign src1Hit = cdbValid && (dispSrc1Tag != tagWidth'(tagFree)) && (dispSrc1Tag == cdbTag);
    assign src2Hit = cdbValid && (dispSrc2Tag != tagWidth'(tagFree)) && (dispSrc2Tag == cdbTag);

    assign issueOp        = entryOp[readyIdx];
    assign issueSrc1      = entrySrc1Data[readyIdx];
    assign issueSrc2      = entrySrc2Data[readyIdx];
    assign issueImm       = entryImm[readyIdx];
    assign issuePc        = entryPc[readyIdx];
    assign issuePredTaken = entryPred[readyIdx];
    assign issueDestTag   = entryDestTag[readyIdx];

    // one entry may fill while another drains
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < rsDepth; i++) begin
                entryOp[i] <= opNop;
            end
        end else begin
            for (int i = 0; i < rsDepth; i++) begin
                if (dispFire && freeIdx == idxWidth'(i)) begin
                    entryOp[i] <= dispOp;
                end else if (issueFire && readyIdx == idxWidth'(i)) begin
                    entryOp[i] <= opNop;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rsDepth; i++) begin
            if (dispFire && freeIdx == idxWidth'(i)) begin
                entrySrc1Data[i] <= src1Hit ? cdbData : dispSrc1Data;
                entrySrc1Tag[i]  <= src1Hit ? tagWidth'(tagFree) : dispSrc1Tag;
                entrySrc2Data[i] <= src2Hit ? cdbData : dispSrc2Data;
                entrySrc2Tag[i]  <= src2Hit ? tagWidth'(tagFree) : dispSrc2Tag;
                entryImm[i]      <= dispImm;
                entryPc[i]       <= dispPc;
                entryPred[i]     <= dispPredTaken;
                entryDestTag[i]  <= dispDestTag;
            end else if (cdbValid && entryOp[i] != opNop) begin
                // wakeup of waiting operands
                if (entrySrc1Tag[i] == cdbTag) begin
                    entrySrc1Data[i] <= cdbData;
                    entrySrc1Tag[i]  <= tagWidth'(tagFree);
                end
                if (entrySrc2Tag[i] == cdbTag) begin
                    entrySrc2Data[i] <= cdbData;
                    entrySrc2Tag[i]  <= tagWidth'(tagFree);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branchEx.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchEx import branchPkg::*; #(
    parameter int tagWidth = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    // issue from station
    input  logic                 issueValid,
    output logic                 issueReady,
    input  branchOpE             issueOp,
    input  logic [dataWidth-1:0] issueSrc1,
    input  logic [dataWidth-1:0] issueSrc2,
    input  logic [dataWidth-1:0] issueImm,
    input  logic [dataWidth-1:0] issuePc,
    input  logic                 issuePredTaken,
    input  logic [tagWidth-1:0]  issueDestTag,
    // resolved result
    output logic                 resValid,
    input  logic                 resReady,
    output logic [tagWidth-1:0]  resDestTag,
    output logic                 resTaken,
    output logic [dataWidth-1:0] resTarget,
    output logic [dataWidth-1:0] resLink,
    output logic                 resMispredict
);

    logic                 taken;
    logic [dataWidth-1:0] pcTarget;
    logic [dataWidth-1:0] regTarget;
    logic [dataWidth-1:0] target;
    logic                 issueFire;

    // direction
    always_comb begin
        case (issueOp)
            opBeq:         taken = (issueSrc1 == issueSrc2);
            opBne:         taken = (issueSrc1 != issueSrc2);
            opBlt:         taken = ($signed(issueSrc1) < $signed(issueSrc2));
            opBge:         taken = ($signed(issueSrc1) >= $signed(issueSrc2));
            opBltu:        taken = (issueSrc1 < issueSrc2);
            opBgeu:        taken = (issueSrc1 >= issueSrc2);
            opJal, opJalr: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

    assign pcTarget  = issuePc + issueImm;
    // jalr drops bit 0 of the sum
    assign regTarget = (issueSrc1 + issueImm) & ~dataWidth'(1);
    assign target    = (issueOp == opJalr) ? regTarget : pcTarget;

    assign issueReady = !resValid || resReady;
    assign issueFire  = issueValid && issueReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (issueFire) begin
            resValid <= 1'b1;
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    // held while the consumer stalls
    always_ff @(posedge clk) begin
        if (issueFire) begin
            resDestTag    <= issueDestTag;
            resTaken      <= taken;
            resTarget     <= target;
            resLink       <= issuePc + dataWidth'(4);
            resMispredict <= taken != issuePredTaken;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnit import branchPkg::*; #(
    parameter int rsDepth  = 4,
    parameter int tagWidth = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    // dispatch
    input  logic                 dispValid,
    input  branchOpE             dispOp,
    input  logic [dataWidth-1:0] dispSrc1Data,
    input  logic [tagWidth-1:0]  dispSrc1Tag,
    input  logic [dataWidth-1:0] dispSrc2Data,
    input  logic [tagWidth-1:0]  dispSrc2Tag,
    input  logic [dataWidth-1:0] dispImm,
    input  logic [dataWidth-1:0] dispPc,
    input  logic                 dispPredTaken,
    input  logic [tagWidth-1:0]  dispDestTag,
    output logic                 dispReady,
    // common data bus
    input  logic                 cdbValid,
    input  logic [tagWidth-1:0]  cdbTag,
    input  logic [dataWidth-1:0] cdbData,
    // result
    output logic                 resValid,
    input  logic                 resReady,
    output logic [tagWidth-1:0]  resDestTag,
    output logic                 resTaken,
    output logic [dataWidth-1:0] resTarget,
    output logic [dataWidth-1:0] resLink,
    output logic                 resMispredict
);

    // station to execute
    logic                 issueValid;
    logic                 issueReady;
    branchOpE             issueOp;
    logic [dataWidth-1:0] issueSrc1;
    logic [dataWidth-1:0] issueSrc2;
    logic [dataWidth-1:0] issueImm;
    logic [dataWidth-1:0] issuePc;
    logic                 issuePredTaken;
    logic [tagWidth-1:0]  issueDestTag;

    branchRs #(
        .rsDepth  (rsDepth),
        .tagWidth (tagWidth)
    ) branchRs_i (
        .clk            (clk),
        .rstN           (rstN),
        .dispValid      (dispValid),
        .dispOp         (dispOp),
        .dispSrc1Data   (dispSrc1Data),
        .dispSrc1Tag    (dispSrc1Tag),
        .dispSrc2Data   (dispSrc2Data),
        .dispSrc2Tag    (dispSrc2Tag),
        .dispImm        (dispImm),
        .dispPc         (dispPc),
        .dispPredTaken  (dispPredTaken),
        .dispDestTag    (dispDestTag),
        .dispReady      (dispReady),
        .cdbValid       (cdbValid),
        .cdbTag         (cdbTag),
        .cdbData        (cdbData),
        .issueValid     (issueValid),
        .issueReady     (issueReady),
        .issueOp        (issueOp),
        .issueSrc1      (issueSrc1),
        .issueSrc2      (issueSrc2),
        .issueImm       (issueImm),
        .issuePc        (issuePc),
        .issuePredTaken (issuePredTaken),
        .issueDestTag   (issueDestTag)
    );

    branchEx #(
        .tagWidth (tagWidth)
    ) branchEx_i (
        .clk            (clk),
        .rstN           (rstN),
        .issueValid     (issueValid),
        .issueReady     (issueReady),
        .issueOp        (issueOp),
        .issueSrc1      (issueSrc1),
        .issueSrc2      (issueSrc2),
        .issueImm       (issueImm),
        .issuePc        (issuePc),
        .issuePredTaken (issuePredTaken),
        .issueDestTag   (issueDestTag),
        .resValid       (resValid),
        .resReady       (resReady),
        .resDestTag     (resDestTag),
        .resTaken       (resTaken),
        .resTarget      (resTarget),
        .resLink        (resLink),
        .resMispredict  (resMispredict)
    );

endmodule

`default_nettype wire

// ==== verification/branchUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnitTb import branchPkg::*; ();

    localparam int rsDepth = 4;

    logic        clk;
    logic        rstN;
    logic        dispValid;
    branchOpE    dispOp;
    logic [31:0] dispSrc1Data;
    logic [3:0]  dispSrc1Tag;
    logic [31:0] dispSrc2Data;
    logic [3:0]  dispSrc2Tag;
    logic [31:0] dispImm;
    logic [31:0] dispPc;
    logic        dispPredTaken;
    logic [3:0]  dispDestTag;
    logic        dispReady;
    logic        cdbValid;
    logic [3:0]  cdbTag;
    logic [31:0] cdbData;
    logic        resValid;
    logic        resReady;
    logic [3:0]  resDestTag;
    logic        resTaken;
    logic [31:0] resTarget;
    logic [31:0] resLink;
    logic        resMispredict;

    // model of in-flight micro-ops by destination tag
    bit          busy  [16];
    branchOpE    mOp   [16];
    logic [31:0] mA    [16];
    logic [31:0] mB    [16];
    logic [31:0] mImm  [16];
    logic [31:0] mPc   [16];
    logic [3:0]  mTagA [16];
    logic [3:0]  mTagB [16];
    logic        mPred [16];
    int          inFlight;
    int          errors;
    int          checks;
    int          results;
    int          accepted;
    int          errStart;
    bit          randomCdb;
    bit          randomReady;

    branchUnit branchUnit_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic takenRule(branchOpE op, logic [31:0] a, logic [31:0] b);
        case (op)
            opBeq:   return a == b;
            opBne:   return a != b;
            opBlt:   return $signed(a) < $signed(b);
            opBge:   return $signed(a) >= $signed(b);
            opBltu:  return a < b;
            opBgeu:  return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] pickValue();
        case ($urandom_range(5, 0))
            0: return 32'h0;
            1: return 32'h1;
            2: return 32'h7fffffff;
            3: return 32'h80000000;
            4: return 32'hffffffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic int freeTag();
        for (int t = 8; t < 16; t++) begin
            if (!busy[t]) return t;
        end
        return 0;
    endfunction

    function automatic logic [3:0] pendingTag();
        for (int t = 8; t < 16; t++) begin
            if (busy[t] && mTagA[t] != 4'(tagFree)) return mTagA[t];
            if (busy[t] && mTagB[t] != 4'(tagFree)) return mTagB[t];
        end
        return 4'(tagFree);
    endfunction

    task automatic checkField(string name, logic [31:0] expVal, logic [31:0] actVal);
        checks++;
        if (expVal !== actVal) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expVal, actVal);
            errors++;
        end
    endtask

    // scoreboard by destination tag
    always @(posedge clk) begin
        int t;
        logic expTaken;
        logic [31:0] expTarget;
        if (rstN && resValid && resReady) begin
            t = int'(resDestTag);
            results++;
            if (!busy[t]) begin
                $display("unexpected or duplicated result for tag %0d at %0t", t, $time);
                errors++;
            end else if (mTagA[t] != 4'(tagFree) || mTagB[t] != 4'(tagFree)) begin
                $display("result for tag %0d at %0t came before its sources", t, $time);
                errors++;
                busy[t] = 1'b0;
                inFlight--;
            end else begin
                expTaken = takenRule(mOp[t], mA[t], mB[t]);
                expTarget = (mOp[t] == opJalr) ? ((mA[t] + mImm[t]) & ~32'h1) : mPc[t] + mImm[t];
                checkField("resTaken", 32'(expTaken), 32'(resTaken));
                checkField("resTarget", expTarget, resTarget);
                checkField("resLink", mPc[t] + 32'h4, resLink);
                checkField("resMispredict", 32'(expTaken != mPred[t]), 32'(resMispredict));
                busy[t] = 1'b0;
                inFlight--;
            end
        end
    end

    task automatic broadcast(logic [3:0] tag, logic [31:0] data);
        cdbValid = 1'b1;
        cdbTag   = tag;
        cdbData  = data;
        for (int t = 8; t < 16; t++) begin
            if (busy[t] && mTagA[t] == tag) begin
                mA[t] = data;
                mTagA[t] = 4'(tagFree);
            end
            if (busy[t] && mTagB[t] == tag) begin
                mB[t] = data;
                mTagB[t] = 4'(tagFree);
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        dispValid = 1'b0;
        cdbValid  = 1'b0;
        if (randomReady) resReady = 1'($urandom_range(1, 0));
        if (randomCdb && $urandom_range(1, 0) == 1) broadcast(4'($urandom_range(7, 1)), $urandom);
    endtask

    task automatic startDispatch(branchOpE op, logic [3:0] ta, logic [31:0] da,
                                 logic [3:0] tb, logic [31:0] db);
        int waitCnt;
        int d;
        waitCnt = 0;
        while ((!dispReady || freeTag() == 0) && waitCnt < 300) begin
            step();
            waitCnt++;
        end
        if (!dispReady || freeTag() == 0) begin
            $display("timeout waiting for a dispatch slot at %0t", $time);
            errors++;
            return;
        end
        d = freeTag();
        busy[d] = 1'b1;
        mOp[d] = op;
        mA[d] = da;
        mB[d] = db;
        mTagA[d] = ta;
        mTagB[d] = tb;
        mImm[d] = pickValue();
        mPc[d] = $urandom;
        mPred[d] = 1'($urandom_range(1, 0));
        // a broadcast already on the bus this cycle reaches the new op too
        if (cdbValid && ta == cdbTag) begin
            mA[d] = cdbData;
            mTagA[d] = 4'(tagFree);
        end
        if (cdbValid && tb == cdbTag) begin
            mB[d] = cdbData;
            mTagB[d] = 4'(tagFree);
        end
        dispValid = 1'b1;
        dispOp = op;
        dispSrc1Tag = ta;
        dispSrc1Data = da;
        dispSrc2Tag = tb;
        dispSrc2Data = db;
        dispImm = mImm[d];
        dispPc = mPc[d];
        dispPredTaken = mPred[d];
        dispDestTag = 4'(d);
        inFlight++;
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (inFlight > 0 && cnt < 500) begin
            if (!cdbValid && pendingTag() != 4'(tagFree) && $urandom_range(2, 0) == 0)
                broadcast(pendingTag(), $urandom);
            step();
            cnt++;
        end
        if (inFlight > 0) begin
            $display("timeout draining results, %0d still outstanding", inFlight);
            errors++;
        end
    endtask

    task automatic endTest(string name);
        $display("test %s done, %0d errors", name, errors - errStart);
        errStart = errors;
    endtask

    function automatic logic [3:0] randTag();
        return ($urandom_range(1, 0) == 1) ? 4'($urandom_range(7, 1)) : 4'(tagFree);
    endfunction

    initial begin
        void'($urandom(32'h9053));
        {dispValid, dispPredTaken, cdbValid, resReady} = '0;
        dispOp = opNop;
        {dispSrc1Data, dispSrc2Data, dispImm, dispPc, cdbData} = '0;
        {dispSrc1Tag, dispSrc2Tag, dispDestTag, cdbTag} = '0;
        {inFlight, errors, checks, results, errStart} = '0;
        {randomCdb, randomReady} = '0;
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        resReady = 1'b1;

        step();
        checkField("resValid", 32'h0, 32'(resValid));
        checkField("dispReady", 32'h1, 32'(dispReady));
        endTest("reset");

        for (int i = 0; i < 80; i++) begin
            startDispatch(branchOpE'($urandom_range(8, 1)), 4'(tagFree), pickValue(),
                          4'(tagFree), pickValue());
            step();
            checkField("resValid", 32'h0, 32'(resValid));
            step();
            checkField("resValid", 32'h1, 32'(resValid));
        end
        step();
        endTest("ready operands");

        randomCdb = 1'b1;
        for (int i = 0; i < 40; i++) begin
            startDispatch(branchOpE'($urandom_range(8, 1)), randTag(), pickValue(),
                          randTag(), pickValue());
            repeat ($urandom_range(3, 1)) step();
        end
        randomCdb = 1'b0;
        drain();
        endTest("cdb wakeup");

        for (int i = 0; i < 12; i++) begin
            accepted = $urandom_range(7, 1);
            startDispatch(branchOpE'($urandom_range(8, 1)), 4'(accepted), pickValue(),
                          4'(tagFree), pickValue());
            broadcast(4'(accepted), pickValue());
            step();
            drain();
        end
        endTest("same-edge bypass");

        resReady = 1'b0;
        accepted = 0;
        for (int i = 0; i < 20 && dispReady; i++) begin
            startDispatch(branchOpE'($urandom_range(8, 1)), 4'(tagFree), pickValue(),
                          4'(tagFree), pickValue());
            step();
            accepted++;
        end
        checkField("accepted count", 32'(rsDepth + 1), 32'(accepted));
        resReady = 1'b1;
        drain();
        endTest("back-pressure");

        randomCdb = 1'b1;
        randomReady = 1'b1;
        for (int i = 0; i < 400; i++) begin
            startDispatch(branchOpE'($urandom_range(8, 1)), randTag(), pickValue(),
                          randTag(), pickValue());
            repeat ($urandom_range(2, 1)) step();
        end
        randomCdb = 1'b0;
        drain();
        randomReady = 1'b0;
        resReady = 1'b1;
        step();
        endTest("random soak");

        $display("tests 6, results %0d, checks %0d, errors %0d", results, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/branchPkg.sv
rtl/branchRs.sv
rtl/branchEx.sv
rtl/branchUnit.sv
verification/branchUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the branch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module branchUnitTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
exit 0
